//--- common/vga_pkg.sv
// VGA raster and drawing definitions

`default_nettype none

package vga_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Shared vector and enum types
    typedef logic [10:0] hcount_t;      // Pixel within line
    typedef logic [10:0] vcount_t;      // Line within frame
    typedef logic [10:0] xpos_t;        // Ball x
    typedef logic [9:0]  ypos_t;        // Ball or paddle y
    typedef logic [3:0]  score_t;       // 0 to 9
    typedef logic [11:0] rgb_t;         // {r, g, b}
    typedef logic [3:0]  char_code_t;
    typedef logic [2:0]  char_line_t;
    typedef logic [7:0]  char_pixels_t; // MSB is leftmost

    typedef enum logic [1:0] {
        GS_IDLE,
        GS_PLAY,
        GS_POINT,
        GS_OVER
    } game_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // VESA 800x600 at 72 Hz, 50 MHz pixel clock
    localparam int H_ACTIVE = 800;
    localparam int H_FRONT  = 56;
    localparam int H_SYNC   = 120;
    localparam int H_TOTAL  = 1040;
    localparam int V_ACTIVE = 600;
    localparam int V_FRONT  = 37;
    localparam int V_SYNC   = 6;
    localparam int V_TOTAL  = 666;

    ////////////////////////////////////////////////////////////////////////////
    // Field geometry
    localparam int BORDER            = 4;
    localparam int CENTER_X0         = 398;
    localparam int CENTER_W          = 4;
    localparam int DASH_BIT          = 4;   // 16-line dashes
    localparam int SCORE_Y0          = 32;
    localparam int SCORE1_X0         = 320;
    localparam int SCORE2_X0         = 448;
    localparam int SCORE_SCALE_SHIFT = 2;
    localparam int SCORE_SIZE        = 8 << SCORE_SCALE_SHIFT;
    localparam int FONT_DEPTH        = 80;  // Ten digits, eight rows each
    localparam int PAD_W             = 8;
    localparam int PAD_H             = 64;
    localparam int PAD_LEFT_X        = 16;
    localparam int PAD_RIGHT_X       = 776;
    localparam int BALL_SIZE         = 8;

    localparam rgb_t COLOR_FIELD = 12'h000;
    localparam rgb_t COLOR_LINE  = 12'hfff;
    localparam rgb_t COLOR_SCORE = 12'hfff;
    localparam rgb_t COLOR_PAD   = 12'h0f0;
    localparam rgb_t COLOR_BALL  = 12'hff0;
    localparam rgb_t COLOR_BLANK = 12'h000;

    localparam int PIPE_LATENCY = 4; // Counters to pins

endpackage

`default_nettype wire

//--- verilog/vga_timing.sv
// VGA raster timing generator

`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic             clk,
    input  logic             rst,
    output logic             timing_tick,
    output vga_pkg::hcount_t hcount,
    output vga_pkg::vcount_t vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             hblnk,
    output logic             vblnk
);

    vga_pkg::hcount_t h_next;
    vga_pkg::vcount_t v_next;

    ////////////////////////////////////////////////////////////////////////////
    // Next raster position
    always_comb begin
        h_next = hcount + 1'b1;
        v_next = vcount;
        if (hcount == vga_pkg::hcount_t'(vga_pkg::H_TOTAL - 1)) begin
            h_next = '0;                // End of line
            if (vcount == vga_pkg::vcount_t'(vga_pkg::V_TOTAL - 1)) begin
                v_next = '0;            // End of frame
            end else begin
                v_next = vcount + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Counters and decodes, all taken from the next position so they line up
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount      <= '0;
            vcount      <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            hblnk       <= 1'b0;
            vblnk       <= 1'b0;
            timing_tick <= 1'b0;
        end else begin
            hcount      <= h_next;
            vcount      <= v_next;
            hsync       <= (h_next >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT) &&
                           (h_next <  vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC);
            vsync       <= (v_next >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT) &&
                           (v_next <  vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC);
            hblnk       <= (h_next >= vga_pkg::H_ACTIVE);
            vblnk       <= (v_next >= vga_pkg::V_ACTIVE);
            timing_tick <= (h_next == '0) && (v_next == vga_pkg::V_ACTIVE); // Start of vblank
        end
    end

    // Counters never leave the frame
    a_count_range: assert property (@(posedge clk) disable iff (rst)
        (hcount < vga_pkg::H_TOTAL) && (vcount < vga_pkg::V_TOTAL));

endmodule

`default_nettype wire

//--- verilog/draw_bg.sv
// Playfield background stage

`timescale 1ns/1ps
`default_nettype none

module draw_bg (
    input  logic             clk,
    input  logic             rst,
    input  vga_pkg::hcount_t hcount_in,
    input  vga_pkg::vcount_t vcount_in,
    input  logic             hsync_in,
    input  logic             vsync_in,
    input  logic             hblnk_in,
    input  logic             vblnk_in,
    output vga_pkg::hcount_t hcount_out,
    output vga_pkg::vcount_t vcount_out,
    output logic             hsync_out,
    output logic             vsync_out,
    output logic             hblnk_out,
    output logic             vblnk_out,
    output vga_pkg::rgb_t    rgb_out
);

    logic          on_border;
    logic          on_center;
    vga_pkg::rgb_t rgb_nxt;

    always_comb begin
        on_border = (hcount_in < vga_pkg::BORDER) ||
                    (hcount_in >= vga_pkg::H_ACTIVE - vga_pkg::BORDER) ||
                    (vcount_in < vga_pkg::BORDER) ||
                    (vcount_in >= vga_pkg::V_ACTIVE - vga_pkg::BORDER);
        on_center = (hcount_in >= vga_pkg::CENTER_X0) &&
                    (hcount_in < vga_pkg::CENTER_X0 + vga_pkg::CENTER_W) &&
                    !vcount_in[vga_pkg::DASH_BIT];   // Gaps on odd dash slots
        if (hblnk_in || vblnk_in)         rgb_nxt = vga_pkg::COLOR_BLANK;
        else if (on_border || on_center)  rgb_nxt = vga_pkg::COLOR_LINE;
        else                              rgb_nxt = vga_pkg::COLOR_FIELD;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {hcount_out, vcount_out} <= '0;
            {hsync_out, vsync_out, hblnk_out, vblnk_out} <= '0;
            rgb_out <= '0;
        end else begin
            {hcount_out, vcount_out} <= {hcount_in, vcount_in};
            {hsync_out, vsync_out, hblnk_out, vblnk_out} <=
                {hsync_in, vsync_in, hblnk_in, vblnk_in};
            rgb_out <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

//--- draw_score/font_rom.sv
// Digit glyph ROM

`timescale 1ns/1ps
`default_nettype none

module font_rom (
    input  logic                  clk,
    input  vga_pkg::char_code_t   char_code,
    input  vga_pkg::char_line_t   char_line,
    output vga_pkg::char_pixels_t char_pixels
);

    vga_pkg::char_pixels_t rom [0:vga_pkg::FONT_DEPTH-1];
    logic [6:0]            addr;

    // Eight rows per digit, so code and line concatenate into the address
    assign addr = {char_code, char_line};

    initial begin
        $readmemh("draw_score/font_digits.dat", rom);
    end

    always_ff @(posedge clk) begin
        char_pixels <= rom[addr];      // One cycle read
    end

endmodule

`default_nettype wire

//--- draw_score/draw_score.sv
// Score digit overlay stage

`timescale 1ns/1ps
`default_nettype none

module draw_score (
    input  logic                  clk,
    input  logic                  rst,
    input  vga_pkg::hcount_t      hcount_in,
    input  vga_pkg::vcount_t      vcount_in,
    input  logic                  hsync_in,
    input  logic                  vsync_in,
    input  logic                  hblnk_in,
    input  logic                  vblnk_in,
    input  vga_pkg::rgb_t         rgb_in,
    output vga_pkg::hcount_t      hcount_out,
    output vga_pkg::vcount_t      vcount_out,
    output logic                  hsync_out,
    output logic                  vsync_out,
    output logic                  hblnk_out,
    output logic                  vblnk_out,
    output vga_pkg::rgb_t         rgb_out,
    input  vga_pkg::score_t       player1_score,
    input  vga_pkg::score_t       player2_score,
    output vga_pkg::char_code_t   char_code,
    output vga_pkg::char_line_t   char_line,
    input  vga_pkg::char_pixels_t char_pixels
);

    logic             in_rows, in_box1, in_box2;
    vga_pkg::hcount_t dx;
    vga_pkg::vcount_t dy;

    // Stage 1 registers, held while the font ROM reads
    vga_pkg::hcount_t hcount_d;
    vga_pkg::vcount_t vcount_d;
    logic             hsync_d, vsync_d, hblnk_d, vblnk_d;
    vga_pkg::rgb_t    rgb_d;
    logic             in_box_d;
    logic [2:0]       col_d;      // Glyph column

    ////////////////////////////////////////////////////////////////////////////
    // Box decode and ROM addressing
    always_comb begin
        in_rows = (vcount_in >= vga_pkg::SCORE_Y0) &&
                  (vcount_in < vga_pkg::SCORE_Y0 + vga_pkg::SCORE_SIZE);
        in_box1 = in_rows && (hcount_in >= vga_pkg::SCORE1_X0) &&
                  (hcount_in < vga_pkg::SCORE1_X0 + vga_pkg::SCORE_SIZE);
        in_box2 = in_rows && (hcount_in >= vga_pkg::SCORE2_X0) &&
                  (hcount_in < vga_pkg::SCORE2_X0 + vga_pkg::SCORE_SIZE);
        dy = vcount_in - vga_pkg::vcount_t'(vga_pkg::SCORE_Y0);
        dx = in_box1 ? hcount_in - vga_pkg::hcount_t'(vga_pkg::SCORE1_X0)
                     : hcount_in - vga_pkg::hcount_t'(vga_pkg::SCORE2_X0);
        char_line = dy[vga_pkg::SCORE_SCALE_SHIFT +: 3];  // Each row four lines tall
        char_code = in_box1 ? player1_score : (in_box2 ? player2_score : '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {hcount_d, vcount_d, hsync_d, vsync_d, hblnk_d, vblnk_d} <= '0;
            rgb_d    <= '0;
            in_box_d <= 1'b0;
            col_d    <= '0;
            {hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out} <= '0;
            rgb_out  <= '0;
        end else begin
            {hcount_d, vcount_d, hsync_d, vsync_d, hblnk_d, vblnk_d} <=
                {hcount_in, vcount_in, hsync_in, vsync_in, hblnk_in, vblnk_in};
            rgb_d    <= rgb_in;
            in_box_d <= in_box1 || in_box2;
            col_d    <= dx[vga_pkg::SCORE_SCALE_SHIFT +: 3];
            // Glyph applied once char_pixels is valid
            {hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out} <=
                {hcount_d, vcount_d, hsync_d, vsync_d, hblnk_d, vblnk_d};
            rgb_out  <= (in_box_d && char_pixels[3'd7 - col_d]) ? vga_pkg::COLOR_SCORE : rgb_d;
        end
    end

    // Font only holds 0 to 9
    a_score_range: assert property (@(posedge clk) disable iff (rst)
        (player1_score <= 4'd9) && (player2_score <= 4'd9));

endmodule

`default_nettype wire

//--- verilog/draw_ball_pads.sv
// Paddles and ball, last drawing stage

`timescale 1ns/1ps
`default_nettype none

module draw_ball_pads (
    input  logic                 clk,
    input  logic                 rst,
    input  vga_pkg::hcount_t     hcount_in,
    input  vga_pkg::vcount_t     vcount_in,
    input  logic                 hsync_in,
    input  logic                 vsync_in,
    input  logic                 hblnk_in,
    input  logic                 vblnk_in,
    input  vga_pkg::rgb_t        rgb_in,
    output logic                 hs,
    output logic                 vs,
    output vga_pkg::rgb_t        rgb,
    input  vga_pkg::xpos_t       x_ball,
    input  vga_pkg::ypos_t       y_ball,
    input  vga_pkg::ypos_t       y_pad_left,
    input  vga_pkg::ypos_t       y_pad_right,
    input  vga_pkg::game_state_t state
);

    vga_pkg::vcount_t top_left, top_right, top_ball;
    logic [11:0]      h_ext, ball_x0;      // Widened so x plus size never wraps
    logic             on_pad, on_ball;
    vga_pkg::rgb_t    rgb_nxt;

    always_comb begin
        top_left  = vga_pkg::vcount_t'(y_pad_left);
        top_right = vga_pkg::vcount_t'(y_pad_right);
        top_ball  = vga_pkg::vcount_t'(y_ball);
        h_ext     = {1'b0, hcount_in};
        ball_x0   = {1'b0, x_ball};
        on_pad  = ((hcount_in >= vga_pkg::PAD_LEFT_X) &&
                   (hcount_in < vga_pkg::PAD_LEFT_X + vga_pkg::PAD_W) &&
                   (vcount_in >= top_left) &&
                   (vcount_in < top_left + vga_pkg::vcount_t'(vga_pkg::PAD_H))) ||
                  ((hcount_in >= vga_pkg::PAD_RIGHT_X) &&
                   (hcount_in < vga_pkg::PAD_RIGHT_X + vga_pkg::PAD_W) &&
                   (vcount_in >= top_right) &&
                   (vcount_in < top_right + vga_pkg::vcount_t'(vga_pkg::PAD_H)));
        on_ball = (state == vga_pkg::GS_PLAY) &&
                  (h_ext >= ball_x0) && (h_ext < ball_x0 + 12'(vga_pkg::BALL_SIZE)) &&
                  (vcount_in >= top_ball) &&
                  (vcount_in < top_ball + vga_pkg::vcount_t'(vga_pkg::BALL_SIZE));
        if (hblnk_in || vblnk_in) rgb_nxt = rgb_in;   // Keep blanking black
        else if (on_ball)         rgb_nxt = vga_pkg::COLOR_BALL;
        else if (on_pad)          rgb_nxt = vga_pkg::COLOR_PAD;
        else                      rgb_nxt = rgb_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hs  <= 1'b0;
            vs  <= 1'b0;
            rgb <= '0;
        end else begin
            hs  <= hsync_in;
            vs  <= vsync_in;
            rgb <= rgb_nxt;
        end
    end

    // Game FSM output must be defined once out of reset
    a_state_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(state));

endmodule

`default_nettype wire

//--- verilog/top_vga.sv
// Paddle game video top level

`timescale 1ns/1ps
`default_nettype none

module top_vga (
    input  logic                 clk,
    input  logic                 rst,
    input  vga_pkg::ypos_t       y_player_1,
    input  vga_pkg::ypos_t       y_player_2,
    input  vga_pkg::xpos_t       x_ball,
    input  vga_pkg::ypos_t       y_ball,
    input  vga_pkg::game_state_t state,
    input  vga_pkg::score_t      player1_score,
    input  vga_pkg::score_t      player2_score,
    output logic                 timing_tick,
    output logic                 vs,
    output logic                 hs,
    output logic [3:0]           r,
    output logic [3:0]           g,
    output logic [3:0]           b
);

    ////////////////////////////////////////////////////////////////////////////
    // Raster links between stages
    vga_pkg::hcount_t      hcount_tim, hcount_bg, hcount_sc;
    vga_pkg::vcount_t      vcount_tim, vcount_bg, vcount_sc;
    logic                  hsync_tim, vsync_tim, hblnk_tim, vblnk_tim;
    logic                  hsync_bg, vsync_bg, hblnk_bg, vblnk_bg;
    logic                  hsync_sc, vsync_sc, hblnk_sc, vblnk_sc;
    vga_pkg::rgb_t         rgb_bg, rgb_sc, rgb_pix;
    vga_pkg::char_code_t   char_code;
    vga_pkg::char_line_t   char_line;
    vga_pkg::char_pixels_t char_pixels;

    assign {r, g, b} = rgb_pix;        // Red in top nibble

    vga_timing u_vga_timing (
        .clk, .rst, .timing_tick,
        .hcount (hcount_tim), .vcount (vcount_tim),
        .hsync  (hsync_tim),  .vsync  (vsync_tim),
        .hblnk  (hblnk_tim),  .vblnk  (vblnk_tim)
    );

    draw_bg u_draw_bg (
        .clk, .rst,
        .hcount_in  (hcount_tim), .vcount_in  (vcount_tim),
        .hsync_in   (hsync_tim),  .vsync_in   (vsync_tim),
        .hblnk_in   (hblnk_tim),  .vblnk_in   (vblnk_tim),
        .hcount_out (hcount_bg),  .vcount_out (vcount_bg),
        .hsync_out  (hsync_bg),   .vsync_out  (vsync_bg),
        .hblnk_out  (hblnk_bg),   .vblnk_out  (vblnk_bg),
        .rgb_out    (rgb_bg)
    );

    draw_score u_draw_score (
        .clk, .rst,
        .hcount_in  (hcount_bg), .vcount_in  (vcount_bg),
        .hsync_in   (hsync_bg),  .vsync_in   (vsync_bg),
        .hblnk_in   (hblnk_bg),  .vblnk_in   (vblnk_bg),
        .rgb_in     (rgb_bg),
        .hcount_out (hcount_sc), .vcount_out (vcount_sc),
        .hsync_out  (hsync_sc),  .vsync_out  (vsync_sc),
        .hblnk_out  (hblnk_sc),  .vblnk_out  (vblnk_sc),
        .rgb_out    (rgb_sc),
        .player1_score, .player2_score,
        .char_code, .char_line, .char_pixels
    );

    font_rom u_font_rom (.clk, .char_code, .char_line, .char_pixels);

    draw_ball_pads u_draw_ball_pads (
        .clk, .rst,
        .hcount_in  (hcount_sc), .vcount_in (vcount_sc),
        .hsync_in   (hsync_sc),  .vsync_in  (vsync_sc),
        .hblnk_in   (hblnk_sc),  .vblnk_in  (vblnk_sc),
        .rgb_in     (rgb_sc),
        .hs, .vs,
        .rgb        (rgb_pix),
        .x_ball, .y_ball,
        .y_pad_left  (y_player_1),
        .y_pad_right (y_player_2),
        .state
    );

endmodule

`default_nettype wire

//--- verif/clk_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;         // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);      // Four reset edges
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/top_vga_tb.sv
// Paddle game video testbench

`timescale 1ns/1ps
`default_nettype none

module top_vga_tb;

    logic                  clk;
    logic                  rst;
    vga_pkg::ypos_t        y_player_1;
    vga_pkg::ypos_t        y_player_2;
    vga_pkg::xpos_t        x_ball;
    vga_pkg::ypos_t        y_ball;
    vga_pkg::game_state_t  state;
    vga_pkg::score_t       player1_score;
    vga_pkg::score_t       player2_score;
    logic                  timing_tick;
    logic                  vs;
    logic                  hs;
    logic [3:0]            r;
    logic [3:0]            g;
    logic [3:0]            b;

    integer                seed;
    vga_pkg::char_pixels_t font [0:vga_pkg::FONT_DEPTH-1];
    int                    mh;                  // Model raster position
    int                    mv;
    logic                  hs_q  [0:vga_pkg::PIPE_LATENCY-1];
    logic                  vs_q  [0:vga_pkg::PIPE_LATENCY-1];
    vga_pkg::rgb_t         rgb_q [0:vga_pkg::PIPE_LATENCY-1];

    clk_gen u_clk_gen (.clk, .rst);

    top_vga UUT (
        .clk, .rst,
        .y_player_1, .y_player_2, .x_ball, .y_ball, .state,
        .player1_score, .player2_score,
        .timing_tick, .vs, .hs, .r, .g, .b
    );

    ////////////////////////////////////////////////////////////////////////////
    // Picture model
    function automatic vga_pkg::rgb_t predict_pixel(input int h, input int v);
        int                    x0;
        int                    code;
        vga_pkg::char_pixels_t row;
        x0   = -1;
        code = 0;
        if (h >= vga_pkg::H_ACTIVE || v >= vga_pkg::V_ACTIVE) return vga_pkg::COLOR_BLANK;
        if (state == vga_pkg::GS_PLAY &&
            h >= int'(x_ball) && h < int'(x_ball) + vga_pkg::BALL_SIZE &&
            v >= int'(y_ball) && v < int'(y_ball) + vga_pkg::BALL_SIZE)
            return vga_pkg::COLOR_BALL;
        if (h >= vga_pkg::PAD_LEFT_X && h < vga_pkg::PAD_LEFT_X + vga_pkg::PAD_W &&
            v >= int'(y_player_1) && v < int'(y_player_1) + vga_pkg::PAD_H)
            return vga_pkg::COLOR_PAD;
        if (h >= vga_pkg::PAD_RIGHT_X && h < vga_pkg::PAD_RIGHT_X + vga_pkg::PAD_W &&
            v >= int'(y_player_2) && v < int'(y_player_2) + vga_pkg::PAD_H)
            return vga_pkg::COLOR_PAD;
        if (v >= vga_pkg::SCORE_Y0 && v < vga_pkg::SCORE_Y0 + vga_pkg::SCORE_SIZE) begin
            if (h >= vga_pkg::SCORE1_X0 && h < vga_pkg::SCORE1_X0 + vga_pkg::SCORE_SIZE) begin
                x0   = vga_pkg::SCORE1_X0;
                code = int'(player1_score);
            end else if (h >= vga_pkg::SCORE2_X0 &&
                         h < vga_pkg::SCORE2_X0 + vga_pkg::SCORE_SIZE) begin
                x0   = vga_pkg::SCORE2_X0;
                code = int'(player2_score);
            end
        end
        if (x0 >= 0) begin
            row = font[code * 8 + ((v - vga_pkg::SCORE_Y0) >> vga_pkg::SCORE_SCALE_SHIFT)];
            if (row[7 - ((h - x0) >> vga_pkg::SCORE_SCALE_SHIFT)]) return vga_pkg::COLOR_SCORE;
        end
        if (h < vga_pkg::BORDER || h >= vga_pkg::H_ACTIVE - vga_pkg::BORDER ||
            v < vga_pkg::BORDER || v >= vga_pkg::V_ACTIVE - vga_pkg::BORDER)
            return vga_pkg::COLOR_LINE;
        if (h >= vga_pkg::CENTER_X0 && h < vga_pkg::CENTER_X0 + vga_pkg::CENTER_W &&
            ((v >> vga_pkg::DASH_BIT) & 1) == 0)
            return vga_pkg::COLOR_LINE;         // Dash slot
        return vga_pkg::COLOR_FIELD;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_sync(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_rgb(input vga_pkg::rgb_t got, input vga_pkg::rgb_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: rgb is %h, expected %h", $time, got, exp);
            $display("Errors found");
            $fatal(1, "rgb mismatch");
        end
    endtask

    task automatic check_tick(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: timing_tick is %b, expected %b at line %0d",
                     $time, got, exp, mv);
            $display("Errors found");
            $fatal(1, "timing_tick mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    task automatic draw_game_inputs();
        int pad1;
        int pick;
        pad1 = $unsigned($random(seed)) % (vga_pkg::V_ACTIVE - vga_pkg::PAD_H);
        pick = $unsigned($random(seed)) % 8;
        y_player_1    <= vga_pkg::ypos_t'(pad1);
        y_player_2    <= vga_pkg::ypos_t'($unsigned($random(seed)) % vga_pkg::V_ACTIVE);
        player1_score <= vga_pkg::score_t'($unsigned($random(seed)) % 10);
        player2_score <= vga_pkg::score_t'($unsigned($random(seed)) % 10);
        state         <= (pick >= 4) ? vga_pkg::GS_PLAY : vga_pkg::game_state_t'(pick);
        if (pick % 2 == 1) begin
            // Ball over the left paddle
            x_ball <= vga_pkg::xpos_t'(vga_pkg::PAD_LEFT_X - 4 +
                                       $unsigned($random(seed)) % vga_pkg::PAD_W);
            y_ball <= vga_pkg::ypos_t'(pad1 + $unsigned($random(seed)) % vga_pkg::PAD_H);
        end else begin
            x_ball <= vga_pkg::xpos_t'($unsigned($random(seed)) % vga_pkg::H_ACTIVE);
            y_ball <= vga_pkg::ypos_t'($unsigned($random(seed)) % vga_pkg::V_ACTIVE);
        end
    endtask

    task automatic wait_for_tick();
        int n;
        n = 0;
        @(negedge clk);
        while (timing_tick !== 1'b1 && n < 2 * vga_pkg::H_TOTAL * vga_pkg::V_TOTAL) begin
            @(negedge clk);
            n++;
        end
        if (timing_tick !== 1'b1) begin
            $display("Timed out after two frames without a timing_tick");
            $display("Errors found");
            $fatal(1, "timing_tick timeout");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Raster model and pin checks sampled mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            check_tick(timing_tick, (mh == 0) && (mv == vga_pkg::V_ACTIVE));
            check_sync(hs, hs_q[vga_pkg::PIPE_LATENCY-1], "hs");
            check_sync(vs, vs_q[vga_pkg::PIPE_LATENCY-1], "vs");
            check_rgb({r, g, b}, rgb_q[vga_pkg::PIPE_LATENCY-1]);
            for (int i = vga_pkg::PIPE_LATENCY - 1; i > 0; i--) begin
                hs_q[i]  = hs_q[i-1];
                vs_q[i]  = vs_q[i-1];
                rgb_q[i] = rgb_q[i-1];
            end
            hs_q[0]  = (mh >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT) &&
                       (mh < vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC);
            vs_q[0]  = (mv >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT) &&
                       (mv < vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC);
            rgb_q[0] = predict_pixel(mh, mv);
            if (mh == vga_pkg::H_TOTAL - 1) begin
                mh = 0;
                mv = (mv == vga_pkg::V_TOTAL - 1) ? 0 : mv + 1;
            end else begin
                mh = mh + 1;
            end
        end
    end

    initial begin
        seed          = 71;
        mh            = 0;
        mv            = 0;
        y_player_1    = '0;
        y_player_2    = '0;
        x_ball        = '0;
        y_ball        = '0;
        state         = vga_pkg::GS_IDLE;
        player1_score = '0;
        player2_score = '0;
        for (int i = 0; i < vga_pkg::PIPE_LATENCY; i++) begin
            hs_q[i]  = 1'b0;                    // Pins read zero out of reset
            vs_q[i]  = 1'b0;
            rgb_q[i] = '0;
        end
        $readmemh("draw_score/font_digits.dat", font);
        @(posedge clk);
        draw_game_inputs();                     // Raster still held in reset
        repeat (3) begin
            wait_for_tick();
            @(posedge clk);
            draw_game_inputs();                 // Lands inside vertical blanking
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- draw_score/font_digits.dat
// Glyph rows in hex with the most significant bit leftmost
// Eight rows per digit, digits 0 to 9 in order
3C
66
6E
76
66
66
3C
00
18
38
18
18
18
18
7E
00
3C
66
06
0C
30
60
7E
00
3C
66
06
1C
06
66
3C
00
0C
1C
3C
6C
7E
0C
0C
00
7E
60
7C
06
06
66
3C
00
3C
60
7C
66
66
66
3C
00
7E
06
0C
18
30
30
30
00
3C
66
66
3C
66
66
3C
00
3C
66
66
3E
06
0C
38
00

//--- all.f
common/vga_pkg.sv
verilog/vga_timing.sv
verilog/draw_bg.sv
draw_score/font_rom.sv
draw_score/draw_score.sv
verilog/draw_ball_pads.sv
verilog/top_vga.sv
verif/clk_gen.sv
verif/top_vga_tb.sv

//--- run_sim.sh
#!/bin/sh
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal --top-module top_vga_tb -f all.f \
    -o sim_top_vga > build.log 2>&1 \
    && ./obj_dir/sim_top_vga > "$LOG" 2>&1 \
    || echo "Build or simulation returned an error status"
grep -q "Errors found" "$LOG" && { cat "$LOG"; exit 1; }
grep -q "No errors" "$LOG" || { echo "No result found in $LOG"; exit 1; }
cat "$LOG"
exit 0
